// File: rtl/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

    // default sizes, the top level passes the real values down
    localparam int DIM_DEF   = 64;
    localparam int CORES_DEF = 4;
    localparam int WORD_DEF  = 16;
    localparam int MAXV_DEF  = 63;

    // derived widths
    localparam int COUNT_W = $clog2(MAXV_DEF + 1);
    // one extra bit for the sign
    localparam int TALLY_W = COUNT_W + 1;
    localparam int REM_W   = (CORES_DEF > 1) ? $clog2(CORES_DEF) : 1;

    typedef logic [DIM_DEF-1:0]        hv_t;
    typedef logic [WORD_DEF-1:0]       word_t;
    typedef logic signed [TALLY_W-1:0] tally_t;
    typedef logic [COUNT_W-1:0]        count_t;
    // 0 means a full last batch
    typedef logic [REM_W-1:0]          rem_t;
    // set bit = vote of that core ignored
    typedef logic [CORES_DEF-1:0]      core_mask_t;

    typedef enum logic [1:0] {IDLE, COLLECT, EMIT} seq_state_t;

    // one hypervector per core, core 0 in the lowest slot
    typedef struct packed {
        hv_t [CORES_DEF-1:0] core;
    } batch_t;

endpackage

`default_nettype wire

// File: rtl/dim_counter.sv
`timescale 1ns/1ps
`default_nettype none

module dim_counter import hdc_pkg::*; #(
    parameter int CORES = CORES_DEF,
    parameter int MAXV  = MAXV_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       update,
    input  core_mask_t votes,
    input  core_mask_t ignore,
    input  logic       tie_bit,
    output logic       sign_bit
);

    tally_t tally;
    tally_t net;
    // tie bit of the most recent batch
    logic   tie_q;

    // +1 for a one, -1 for a zero, skipped cores add nothing
    always_comb begin
        net = '0;
        for (int c = 0; c < CORES; c++) begin
            if (!ignore[c]) begin
                if (votes[c]) begin
                    net = net + tally_t'(1);
                end else begin
                    net = net - tally_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            tally <= '0;
        end else if (update) begin
            tally <= tally + net;
        end
    end

    always_ff @(posedge clk) begin
        if (update) begin
            tie_q <= tie_bit;
        end
    end

    // majority decision, zero tally falls back to the tie bit
    always_comb begin
        if (tally == '0) begin
            sign_bit = tie_q;
        end else begin
            sign_bit = ~tally[TALLY_W-1];
        end
    end

    // job length caps the number of votes, so the tally stays in range
    a_tally_range : assert property (@(posedge clk) disable iff (!rst_n)
        (tally <= MAXV) && (tally >= -MAXV));

endmodule

`default_nettype wire

// File: rtl/bundle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_sequencer import hdc_pkg::*; #(
    parameter int CORES = CORES_DEF,
    parameter int MAXV  = MAXV_DEF
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  count_t n_vec,
    input  logic   batch_v,
    input  logic   out_busy,
    output logic   clear,
    output logic   update,
    output logic   last_update,
    output logic   stream_v,
    output rem_t   remainder,
    output logic   idle
);

    // seen can run past n_vec by up to CORES-1 on the last batch
    localparam int SEEN_W = $clog2(MAXV + CORES + 1);

    seq_state_t        state;
    count_t            n_vec_q;
    logic [SEEN_W-1:0] seen;
    logic [SEEN_W-1:0] seen_next;
    // vectors still owed when this batch arrives
    logic [SEEN_W-1:0] left;
    logic              is_last;

    assign idle     = (state == IDLE);
    assign stream_v = (state == EMIT);

    // start only counts when the output side is free as well
    assign clear  = start && idle && !out_busy;
    assign update = batch_v && (state == COLLECT);

    assign seen_next = seen + SEEN_W'(CORES);
    assign left      = SEEN_W'(n_vec_q) - seen;
    assign is_last   = (seen_next >= SEEN_W'(n_vec_q));

    assign last_update = update && is_last;

    // partial last batch: only cores below the remainder vote
    always_comb begin
        remainder = '0;
        if (last_update && (left < SEEN_W'(CORES))) begin
            remainder = rem_t'(left);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (clear) begin
                        state <= COLLECT;
                    end
                end
                COLLECT: begin
                    if (last_update) begin
                        state <= EMIT;
                    end
                end
                EMIT: begin
                    // single cycle, stream_v pulse
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            n_vec_q <= n_vec;
            seen    <= '0;
        end else if (update) begin
            seen <= seen_next;
        end
    end

    // remainder is n_vec mod CORES on the last batch, zero elsewhere
    a_rem_only_last : assert property (@(posedge clk) disable iff (!rst_n)
        remainder == (last_update ? rem_t'(n_vec_q % CORES) : rem_t'(0)));

    // batches taken match ceil(n_vec/CORES)
    a_stream_after_last : assert property (@(posedge clk) disable iff (!rst_n)
        stream_v |-> ($past(last_update)
                      && (seen == SEEN_W'((n_vec_q + CORES - 1) / CORES * CORES))));

endmodule

`default_nettype wire

// File: rtl/bundle_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module bundle_buffer import hdc_pkg::*; #(
    parameter int DIM   = DIM_DEF,
    parameter int CORES = CORES_DEF,
    parameter int MAXV  = MAXV_DEF
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   clear,
    input  logic   update,
    input  logic   last_update,
    input  rem_t   remainder,
    input  batch_t batch,
    input  hv_t    tie_hv,
    input  logic   stream_v,
    output hv_t    result,
    output logic   hv_valid
);

    core_mask_t     ignore;
    logic [DIM-1:0] sign_bits;

    // cores at or above the remainder sit out the last batch
    always_comb begin
        ignore = '0;
        if (last_update && (remainder != '0)) begin
            for (int c = 0; c < CORES; c++) begin
                ignore[c] = (c >= remainder);
            end
        end
    end

    for (genvar d = 0; d < DIM; d++) begin : g_dim
        core_mask_t votes;

        // bit d of every core
        always_comb begin
            for (int c = 0; c < CORES; c++) begin
                votes[c] = batch.core[c][d];
            end
        end

        dim_counter #(
            .CORES(CORES),
            .MAXV (MAXV)
        ) u_cnt (
            .clk     (clk),
            .rst_n   (rst_n),
            .clear   (clear),
            .update  (update),
            .votes   (votes),
            .ignore  (ignore),
            .tie_bit (tie_hv[d]),
            .sign_bit(sign_bits[d])
        );
    end

    // tallies already hold the last batch when stream_v is up
    always_ff @(posedge clk) begin
        if (stream_v) begin
            result <= sign_bits;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hv_valid <= 1'b0;
        end else begin
            hv_valid <= stream_v;
        end
    end

endmodule

`default_nettype wire

// File: rtl/hv_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module hv_serializer import hdc_pkg::*; #(
    parameter int DIM  = DIM_DEF,
    parameter int WORD = WORD_DEF
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  hv_valid,
    input  hv_t   result,
    output logic  word_v,
    output word_t word,
    output logic  word_last,
    output logic  out_busy
);

    localparam int NWORDS = DIM / WORD;
    localparam int IDX_W  = (NWORDS > 1) ? $clog2(NWORDS) : 1;

    logic [DIM-1:0]   shreg;
    logic [IDX_W-1:0] idx;
    // high while words are leaving
    logic             busy_q;

    assign word_v    = busy_q;
    assign word      = shreg[WORD-1:0];
    assign word_last = busy_q && (idx == IDX_W'(NWORDS - 1));
    // load cycle counts as busy too
    assign out_busy  = hv_valid || busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx    <= '0;
        end else if (hv_valid) begin
            busy_q <= 1'b1;
            idx    <= '0;
        end else if (busy_q) begin
            idx <= idx + 1'b1;
            if (word_last) begin
                busy_q <= 1'b0;
            end
        end
    end

    // lowest word first, shift down one word per cycle
    always_ff @(posedge clk) begin
        if (hv_valid) begin
            shreg <= result;
        end else if (busy_q) begin
            shreg <= shreg >> WORD;
        end
    end

    // ready gating upstream should keep jobs from overlapping
    a_no_overrun : assert property (@(posedge clk) disable iff (!rst_n)
        hv_valid |-> !busy_q);

endmodule

`default_nettype wire

// File: rtl/hdc_bundler_top.sv
`timescale 1ns/1ps
`default_nettype none

module hdc_bundler_top import hdc_pkg::*; #(
    parameter int DIM   = DIM_DEF,
    parameter int CORES = CORES_DEF,
    parameter int WORD  = WORD_DEF,
    parameter int MAXV  = MAXV_DEF
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  count_t n_vec,
    input  logic   batch_v,
    input  batch_t batch,
    input  hv_t    tie_hv,
    output logic   ready,
    output logic   word_v,
    output word_t  word,
    output logic   word_last
);

    // sequencer to buffer
    logic clear;
    logic update;
    logic last_update;
    logic stream_v;
    rem_t remainder;
    logic idle;

    // buffer to serializer
    hv_t  result;
    logic hv_valid;
    logic out_busy;

    // new job only when nothing is in flight
    assign ready = idle && !out_busy;

    bundle_sequencer #(
        .CORES(CORES),
        .MAXV (MAXV)
    ) u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .n_vec      (n_vec),
        .batch_v    (batch_v),
        .out_busy   (out_busy),
        .clear      (clear),
        .update     (update),
        .last_update(last_update),
        .stream_v   (stream_v),
        .remainder  (remainder),
        .idle       (idle)
    );

    bundle_buffer #(
        .DIM  (DIM),
        .CORES(CORES),
        .MAXV (MAXV)
    ) u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .update     (update),
        .last_update(last_update),
        .remainder  (remainder),
        .batch      (batch),
        .tie_hv     (tie_hv),
        .stream_v   (stream_v),
        .result     (result),
        .hv_valid   (hv_valid)
    );

    hv_serializer #(
        .DIM (DIM),
        .WORD(WORD)
    ) u_ser (
        .clk      (clk),
        .rst_n    (rst_n),
        .hv_valid (hv_valid),
        .result   (result),
        .word_v   (word_v),
        .word     (word),
        .word_last(word_last),
        .out_busy (out_busy)
    );

endmodule

`default_nettype wire

// File: sim/tb_hdc_bundler.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_bundler import hdc_pkg::*; ();

    localparam int DIM     = 64;
    localparam int CORES   = 4;
    localparam int WORD    = 16;
    localparam int MAXV    = 63;
    localparam int NWORDS  = DIM / WORD;
    localparam int NJOBS   = 10;
    localparam int TIMEOUT = 200;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   start;
    count_t n_vec;
    logic   batch_v;
    batch_t batch;
    hv_t    tie_hv;
    logic   ready;
    logic   word_v;
    word_t  word;
    logic   word_last;

    // job table: length, tie mode, gap cycles before each batch, extra start
    // tie mode 0 random votes, 1 paired votes, 2 paired votes with all-ones tie
    int job_len   [NJOBS] = '{4, 8, 32, 1, 5, 7, 63, 8, 6, 7};
    int job_tie   [NJOBS] = '{0, 0, 0, 0, 0, 0, 0, 1, 2, 1};
    int job_gap   [NJOBS] = '{0, 1, 0, 2, 0, 1, 0, 0, 3, 0};
    int job_extra [NJOBS] = '{0, 1, 0, 0, 1, 0, 1, 0, 1, 0};

    integer seed;
    int     mismatches = 0;
    int     timeouts   = 0;

    hdc_bundler_top #(
        .DIM  (DIM),
        .CORES(CORES),
        .WORD (WORD),
        .MAXV (MAXV)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .n_vec    (n_vec),
        .batch_v  (batch_v),
        .batch    (batch),
        .tie_hv   (tie_hv),
        .ready    (ready),
        .word_v   (word_v),
        .word     (word),
        .word_last(word_last)
    );

    // 10 ns period
    always #5 clk = ~clk;

    task automatic check_equal(input logic [DIM-1:0] got, input logic [DIM-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic make_random(output hv_t v);
        for (int i = 0; i < DIM; i += 32) begin
            v[i +: 32] = $random(seed);
        end
    endtask

    // sampled on the falling edge, away from the driving edge
    task automatic wait_ready(output bit ok);
        int n;
        n = 0;
        while (!ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = ready;
        if (!ok) begin
            $display("ready did not come back within %0d cycles at %0t", TIMEOUT, $time);
            timeouts++;
        end
    endtask

    task automatic wait_word(output bit ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!word_v && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = word_v;
        if (!ok) begin
            $display("no output word within %0d cycles at %0t", TIMEOUT, $time);
            timeouts++;
        end
    endtask

    task automatic run_job(input int idx);
        int     n;
        int     nb;
        int     k;
        int     ones  [DIM];
        int     zeros [DIM];
        bit     ok;
        hv_t    vec;
        hv_t    prev;
        hv_t    tie;
        hv_t    junk;
        hv_t    exp_hv;
        batch_t bv;
        n    = job_len[idx];
        nb   = (n + CORES - 1) / CORES;
        prev = '0;
        tie  = '0;
        for (int d = 0; d < DIM; d++) begin
            ones[d]  = 0;
            zeros[d] = 0;
        end
        // stray batch while idle, must leave no trace
        if (job_extra[idx] != 0) begin
            make_random(junk);
            @(posedge clk);
            batch_v <= 1'b1;
            batch   <= {CORES{junk}};
        end
        @(posedge clk);
        batch_v <= 1'b0;
        start   <= 1'b1;
        n_vec   <= count_t'(n);
        for (int b = 0; b < nb; b++) begin
            repeat (job_gap[idx]) begin
                @(posedge clk);
                start   <= 1'b0;
                batch_v <= 1'b0;
            end
            for (int c = 0; c < CORES; c++) begin
                k = b * CORES + c;
                // odd vector mirrors the one before it, so pairs cancel
                if (job_tie[idx] != 0 && (k % 2) == 1) begin
                    vec = ~prev;
                end else begin
                    make_random(vec);
                end
                prev       = vec;
                bv.core[c] = vec;
                // slots past the job length only carry noise
                if (k < n) begin
                    for (int d = 0; d < DIM; d++) begin
                        if (vec[d]) begin
                            ones[d]++;
                        end else begin
                            zeros[d]++;
                        end
                    end
                end
            end
            if (job_tie[idx] == 2) begin
                tie = '1;
            end else begin
                make_random(tie);
            end
            @(posedge clk);
            batch_v <= 1'b1;
            batch   <= bv;
            tie_hv  <= tie;
            // start while busy, with a length that would spoil the result
            start   <= (job_extra[idx] != 0) && (b == 0);
            n_vec   <= count_t'(MAXV);
        end
        @(posedge clk);
        batch_v <= 1'b0;
        start   <= 1'b0;
        // start while the result heads for the serializer, held off by out_busy
        if (job_extra[idx] != 0) begin
            @(posedge clk);
            start <= 1'b1;
            n_vec <= count_t'(MAXV);
            @(posedge clk);
            start <= 1'b0;
        end
        // majority per dimension, tie bit of the last batch on a draw
        for (int d = 0; d < DIM; d++) begin
            if (ones[d] > zeros[d]) begin
                exp_hv[d] = 1'b1;
            end else if (ones[d] < zeros[d]) begin
                exp_hv[d] = 1'b0;
            end else begin
                exp_hv[d] = tie[d];
            end
        end
        wait_word(ok);
        if (ok) begin
            for (int w = 0; w < NWORDS; w++) begin
                check_equal(word_v, 1, $sformatf("job %0d word_v %0d", idx, w));
                check_equal(word, exp_hv[w*WORD +: WORD],
                            $sformatf("job %0d word %0d", idx, w));
                check_equal(word_last, (w == NWORDS - 1),
                            $sformatf("job %0d word_last %0d", idx, w));
                @(negedge clk);
            end
            check_equal(word_v, 0, $sformatf("job %0d word_v after stream", idx));
            check_equal(ready, 1, $sformatf("job %0d ready after stream", idx));
        end
    endtask

    initial begin
        bit ok;
        seed = 32'h4f8a_4583;
        rst_n   <= 1'b0;
        start   <= 1'b0;
        n_vec   <= '0;
        batch_v <= 1'b0;
        batch   <= '0;
        tie_hv  <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // quiet output before the first job
        repeat (4) begin
            @(negedge clk);
            check_equal(ready, 1, "ready after reset");
            check_equal(word_v, 0, "word_v after reset");
            check_equal(word_last, 0, "word_last after reset");
        end
        // next job starts as soon as ready is seen
        for (int j = 0; j < NJOBS; j++) begin
            wait_ready(ok);
            if (ok) begin
                run_job(j);
            end
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
rtl/hdc_pkg.sv
rtl/dim_counter.sv
rtl/bundle_sequencer.sv
rtl/bundle_buffer.sv
rtl/hv_serializer.sv
rtl/hdc_bundler_top.sv
sim/tb_hdc_bundler.sv

// File: Makefile
TOP = tb_hdc_bundler
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
